/* Makefile */
# Verilator build and run of the BIU testbench

OBJ  = obj_dir
SRCS = src/biu_pkg.sv src/biu_ahb_master.sv src/ahb_sram_slave.sv src/biu_subsys.sv \
       bench/biu_tb.sv bench/biu_tb_tasks.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(OBJ)/Vbiu_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module biu_tb -Mdir $(OBJ)

run: $(OBJ)/Vbiu_tb
	./$(OBJ)/Vbiu_tb | tee sim.log
	grep -q -F '*** TEST PASSED ***' sim.log

clean:
	rm -rf $(OBJ) sim.log

/* bench/biu_tb_tasks.svh */
`ifndef BIU_TB_TASKS_SVH
`define BIU_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_data(input string name, input biu_pkg::data_t exp,
                          input biu_pkg::data_t act);
  if (act !== exp)
    fail_stop($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_addr(input string name, input biu_pkg::addr_t exp,
                          input biu_pkg::addr_t act);
  if (act !== exp)
    fail_stop($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp)
    fail_stop($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (act != exp)
    fail_stop($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
endtask

//////////////////////////////////////////////////////////////////////
// reference rules
//////////////////////////////////////////////////////////////////////

function automatic int beats_of(input biu_pkg::btype_t bt);
  case (bt)
    biu_pkg::WRAP4, biu_pkg::INCR4:   return 4;
    biu_pkg::WRAP8, biu_pkg::INCR8:   return 8;
    biu_pkg::WRAP16, biu_pkg::INCR16: return 16;
    default:                          return 1;
  endcase
endfunction

// wrap window = beats x 4 bytes, word-aligned starts only
function automatic biu_pkg::addr_t beat_addr(input biu_pkg::addr_t start,
                                             input biu_pkg::btype_t bt, input int k);
  biu_pkg::addr_t span;
  biu_pkg::addr_t base;
  span = '0;
  if (bt == biu_pkg::WRAP4 || bt == biu_pkg::WRAP8 || bt == biu_pkg::WRAP16)
    span = biu_pkg::addr_t'(4 * beats_of(bt));
  if (span == '0) begin
    return start + biu_pkg::addr_t'(4 * k);
  end else begin
    base = start & ~(span - 1);
    return base + ((start - base + biu_pkg::addr_t'(4 * k)) % span);
  end
endfunction

function automatic logic [biu_pkg::MEM_AW-1:0] word_index(input biu_pkg::addr_t a);
  return a[biu_pkg::MEM_AW+1:2];  // sram aliases every 1 KiB
endfunction

// only the lanes covered by a naturally aligned access change
function automatic void model_write(input biu_pkg::addr_t a, input biu_pkg::size_t size,
                                    input biu_pkg::data_t d);
  int nbytes;
  int first;
  nbytes = 1 << size;
  first  = int'(a[1:0]) & ~(nbytes - 1);
  for (int b = first; b < first + nbytes; b++)
    ref_mem[word_index(a)][8*b +: 8] = d[8*b +: 8];
endfunction

//////////////////////////////////////////////////////////////////////
// drivers
//////////////////////////////////////////////////////////////////////

// one strobe, all beats; sample at negedge, drive 1 unit after posedge
task automatic run_xfer(input string name, input biu_pkg::addr_t adr,
                        input biu_pkg::size_t size, input biu_pkg::btype_t bt,
                        input logic we, input logic exp_err);
  biu_pkg::data_t    wbuf [16];
  biu_pkg::biu_req_t req;
  biu_pkg::addr_t    exp_adr;
  int                n;
  int                n_dack;
  int                n_ack;
  logic              done;
  logic              first_cycle;
  logic              s_stb_ack;
  logic              s_dack;
  logic              s_ack;
  logic              s_err;
  n = beats_of(bt);
  for (int k = 0; k < n; k++)
    wbuf[k] = $random(seed);
  req.adr   = adr;
  req.size  = size;
  req.btype = bt;
  req.prot  = biu_pkg::PROT_DATA | biu_pkg::PROT_PRIVILEGED;
  req.lock  = 1'b0;
  req.we    = we;
  stb_i     = 1'b1;
  req_i     = req;
  wdata_i   = wbuf[0];
  n_dack      = 0;
  n_ack       = 0;
  done        = 1'b0;
  first_cycle = 1'b1;
  while (!done) begin
    @(negedge HCLK);
    s_stb_ack = stb_ack_o;
    s_dack    = d_ack_o;
    s_ack     = ack_o;
    s_err     = err_o;
    if (first_cycle)
      accept_at_once = s_stb_ack;
    first_cycle = 1'b0;
    if (exp_err)
      check_flag({name, " ack_o"}, 1'b0, s_ack);  // failed beat never acked
    else
      check_flag({name, " err_o"}, 1'b0, s_err);
    if (s_ack) begin
      exp_adr = beat_addr(adr, bt, n_ack);
      check_addr({name, " adr_o"}, exp_adr, adr_o);
      if (we)
        model_write(exp_adr, size, wbuf[n_ack]);
      else
        check_data({name, " rdata_o"}, ref_mem[word_index(exp_adr)], rdata_o);
      n_ack++;
    end
    if (s_dack)
      n_dack++;
    done = exp_err ? s_err : (n_ack == n);
    @(posedge HCLK);
    #1;
    if (s_stb_ack)
      stb_i = 1'b0;  // accepted at that edge
    if (s_dack && n_dack < n)
      wdata_i = wbuf[n_dack];  // next beat's data
  end
  if (!exp_err)
    check_count({name, " d_ack_o pulses"}, n, n_dack);
endtask

task automatic quiet_cycles(input string name, input int n);
  repeat (n) begin
    @(negedge HCLK);
    check_flag({name, " ack_o"}, 1'b0, ack_o);
    check_flag({name, " err_o"}, 1'b0, err_o);
    check_flag({name, " d_ack_o"}, 1'b0, d_ack_o);
    @(posedge HCLK);
    #1;
  end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic reset_idle_test();
  quiet_cycles("reset_idle", 10);
  run_xfer("first_wr", 32'h0, SZ_WORD, biu_pkg::SINGLE, 1'b1, 1'b0);
  check_flag("first_wr stb_ack_o", 1'b1, accept_at_once);
endtask

task automatic single_word_test();
  for (int k = 0; k < 4; k++)
    run_xfer("word_wr", 32'h40 + biu_pkg::addr_t'(4 * k), SZ_WORD, biu_pkg::SINGLE,
             1'b1, 1'b0);
  for (int k = 0; k < 4; k++)
    run_xfer("word_rd", 32'h40 + biu_pkg::addr_t'(4 * k), SZ_WORD, biu_pkg::SINGLE,
             1'b0, 1'b0);
endtask

task automatic sized_write_test();
  run_xfer("sized_base_wr", 32'h80, SZ_WORD, biu_pkg::SINGLE, 1'b1, 1'b0);
  run_xfer("sized_base_wr", 32'h84, SZ_WORD, biu_pkg::SINGLE, 1'b1, 1'b0);
  run_xfer("byte_wr", 32'h81, SZ_BYTE, biu_pkg::SINGLE, 1'b1, 1'b0);
  run_xfer("byte_wr", 32'h83, SZ_BYTE, biu_pkg::SINGLE, 1'b1, 1'b0);
  run_xfer("hword_wr", 32'h86, SZ_HWORD, biu_pkg::SINGLE, 1'b1, 1'b0);
  run_xfer("byte_wr", 32'h84, SZ_BYTE, biu_pkg::SINGLE, 1'b1, 1'b0);
  run_xfer("sized_rd", 32'h80, SZ_WORD, biu_pkg::SINGLE, 1'b0, 1'b0);
  run_xfer("sized_rd", 32'h84, SZ_WORD, biu_pkg::SINGLE, 1'b0, 1'b0);
endtask

task automatic incr_burst_test();
  run_xfer("incr4_wr", 32'h100, SZ_WORD, biu_pkg::INCR4, 1'b1, 1'b0);
  run_xfer("incr4_rd", 32'h100, SZ_WORD, biu_pkg::INCR4, 1'b0, 1'b0);
  run_xfer("incr8_wr", 32'h140, SZ_WORD, biu_pkg::INCR8, 1'b1, 1'b0);
  run_xfer("incr8_rd", 32'h140, SZ_WORD, biu_pkg::INCR8, 1'b0, 1'b0);
endtask

// starts mid-window so the address wraps back to the boundary
task automatic wrap_burst_test();
  run_xfer("wrap4_wr", 32'h1C8, SZ_WORD, biu_pkg::WRAP4, 1'b1, 1'b0);
  for (int k = 0; k < 4; k++)
    run_xfer("wrap4_chk", 32'h1C0 + biu_pkg::addr_t'(4 * k), SZ_WORD, biu_pkg::SINGLE,
             1'b0, 1'b0);
  run_xfer("wrap8_wr", 32'h214, SZ_WORD, biu_pkg::WRAP8, 1'b1, 1'b0);
  run_xfer("wrap8_rd", 32'h20C, SZ_WORD, biu_pkg::WRAP8, 1'b0, 1'b0);
  for (int k = 0; k < 8; k++)
    run_xfer("wrap8_chk", 32'h200 + biu_pkg::addr_t'(4 * k), SZ_WORD, biu_pkg::SINGLE,
             1'b0, 1'b0);
endtask

task automatic error_region_test();
  run_xfer("err_incr4_wr", biu_pkg::ERR_BASE, SZ_WORD, biu_pkg::INCR4, 1'b1, 1'b1);
  quiet_cycles("err_after_burst", 3);  // no second err_o, no late ack_o
  run_xfer("err_single_rd", biu_pkg::ERR_BASE + 32'h10, SZ_WORD, biu_pkg::SINGLE,
           1'b0, 1'b1);
  quiet_cycles("err_after_single", 3);
  run_xfer("after_err_rd", 32'h104, SZ_WORD, biu_pkg::SINGLE, 1'b0, 1'b0);
endtask

`endif

/* bench/biu_tb.sv */
`default_nettype none

module biu_tb;

  localparam int HALF_PERIOD    = 5;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = 2000;  // whole sequence runs about 300 cycles

  localparam biu_pkg::size_t SZ_BYTE  = 3'd0;
  localparam biu_pkg::size_t SZ_HWORD = 3'd1;
  localparam biu_pkg::size_t SZ_WORD  = 3'd2;

  logic              HCLK;
  logic              HRESETn;
  logic              stb_i;
  biu_pkg::biu_req_t req_i;
  biu_pkg::data_t    wdata_i;
  logic              stb_ack_o;
  logic              d_ack_o;
  biu_pkg::addr_t    adr_o;
  biu_pkg::data_t    rdata_o;
  logic              ack_o;
  logic              err_o;

  biu_pkg::data_t ref_mem [biu_pkg::MEM_WORDS];  // expected sram contents
  int             seed;
  int             cycle_cnt;
  logic           accept_at_once;  // stb_ack_o in the strobe's first cycle

  biu_subsys biu_subsys_inst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .stb_i     (stb_i),
    .req_i     (req_i),
    .wdata_i   (wdata_i),
    .stb_ack_o (stb_ack_o),
    .d_ack_o   (d_ack_o),
    .adr_o     (adr_o),
    .rdata_o   (rdata_o),
    .ack_o     (ack_o),
    .err_o     (err_o)
  );

  always #HALF_PERIOD HCLK = ~HCLK;

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  //////////////////////////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////////////////////////

  always @(posedge HCLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      fail_stop($sformatf("timeout: sequence still running after %0d cycles", TIMEOUT_CYCLES));
  end

  `include "biu_tb_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 49715;
    cycle_cnt      = 0;
    accept_at_once = 1'b0;
    HCLK           = 1'b0;
    HRESETn        = 1'b0;
    stb_i          = 1'b0;
    req_i          = '0;
    wdata_i        = '0;
    repeat (RESET_CYCLES) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    reset_idle_test();
    single_word_test();
    sized_write_test();
    incr_burst_test();
    wrap_burst_test();
    error_region_test();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* src/ahb_sram_slave.sv */
`default_nettype none

module ahb_sram_slave #(
  parameter int WAIT_STATES = 1  // 0 to 3
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  biu_pkg::ahb_m2s_t ahb_i,
  output biu_pkg::ahb_s2m_t ahb_o
);

  // byte lanes touched by a sized access
  function automatic logic [3:0] lanes(input biu_pkg::hsize_t size, input logic [1:0] a);
    case (size)
      biu_pkg::HSIZE_BYTE:  return 4'b0001 << a;
      biu_pkg::HSIZE_HWORD: return a[1] ? 4'b1100 : 4'b0011;
      default:              return 4'b1111;
    endcase
  endfunction

  biu_pkg::data_t mem [biu_pkg::MEM_WORDS];

  logic                        dphase;   // transfer in data phase
  logic                        err_q;    // it hit the error region
  logic                        err_2nd;  // second error cycle
  logic [3:0]                  ws_cnt;   // wait states still to insert
  logic                        write_q;
  logic                        hready;
  logic                        start;
  logic [3:0]                  be;
  logic [biu_pkg::MEM_AW-1:0]  idx;
  biu_pkg::addr_t              addr_q;
  biu_pkg::hsize_t             size_q;
  biu_pkg::data_t              rdata;

  //////////////////////////////////////////////////////////////////////
  // address phase capture and wait states
  //////////////////////////////////////////////////////////////////////

  assign start = ahb_i.hsel & hready &
                 ((ahb_i.htrans == biu_pkg::NONSEQ) | (ahb_i.htrans == biu_pkg::SEQ));

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dphase  <= 1'b0;
      err_q   <= 1'b0;
      err_2nd <= 1'b0;
      ws_cnt  <= '0;
    end else if (hready) begin  // idle or data phase ends here
      dphase  <= start;
      err_q   <= start & (ahb_i.haddr >= biu_pkg::ERR_BASE);
      err_2nd <= 1'b0;
      ws_cnt  <= 4'(WAIT_STATES);
    end else if (err_q) begin
      err_2nd <= 1'b1;  // hready goes high next
    end else begin
      ws_cnt <= ws_cnt - 4'd1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (start) begin
      addr_q  <= ahb_i.haddr;
      write_q <= ahb_i.hwrite;
      size_q  <= ahb_i.hsize;
    end
  end

  // error skips wait states, straight into the two-cycle response
  assign hready = ~dphase | (err_q ? err_2nd : (ws_cnt == 4'd0));

  //////////////////////////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////////////////////////

  assign idx = addr_q[biu_pkg::MEM_AW+1:2];  // word index
  assign be  = lanes(size_q, addr_q[1:0]);

  // hwdata valid in the last data-phase cycle
  always_ff @(posedge HCLK) begin
    if (dphase && !err_q && write_q && hready) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i])
          mem[idx][8*i +: 8] <= ahb_i.hwdata[8*i +: 8];
      end
    end
  end

  assign rdata = err_q ? '0 : mem[idx];  // whole word, lanes picked by master

  assign ahb_o = '{hrdata: rdata,
                   hready: hready,
                   hresp:  (dphase & err_q) ? biu_pkg::HRESP_ERROR : biu_pkg::HRESP_OKAY};

  // master only ever issues byte, halfword or word
  a_size_legal: assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase |-> (size_q <= biu_pkg::HSIZE_WORD));

endmodule

`default_nettype wire

/* src/biu_ahb_master.sv */
`default_nettype none

module biu_ahb_master (
  input  logic              HCLK,
  input  logic              HRESETn,
  // core port
  input  logic              stb_i,
  input  biu_pkg::biu_req_t req_i,
  input  biu_pkg::data_t    wdata_i,
  output logic              stb_ack_o,  // request taken
  output logic              d_ack_o,    // address phase, supply write data
  output biu_pkg::addr_t    adr_o,
  output biu_pkg::data_t    rdata_o,
  output logic              ack_o,      // data phase done
  output logic              err_o,
  // AHB-Lite
  output biu_pkg::ahb_m2s_t ahb_o,
  input  biu_pkg::ahb_s2m_t ahb_i
);

  typedef enum logic [1:0] {
    ST_IDLE,   // nothing on the address bus
    ST_BURST,  // some beat in its address phase
    ST_ABORT   // second cycle of an error response
  } state_t;

  //////////////////////////////////////////////////////////////////////
  // code translation
  //////////////////////////////////////////////////////////////////////

  function automatic biu_pkg::hsize_t size2hsize(input biu_pkg::size_t size);
    case (size)
      3'd0:    return biu_pkg::HSIZE_BYTE;
      3'd1:    return biu_pkg::HSIZE_HWORD;
      default: return biu_pkg::HSIZE_WORD;  // no doubleword on 32 bits
    endcase
  endfunction

  // number of beats, counted including the first one
  function automatic logic [4:0] type2len(input biu_pkg::btype_t btype);
    case (btype)
      biu_pkg::WRAP4, biu_pkg::INCR4:   return 5'd4;
      biu_pkg::WRAP8, biu_pkg::INCR8:   return 5'd8;
      biu_pkg::WRAP16, biu_pkg::INCR16: return 5'd16;
      default:                          return 5'd1;  // single and open incr
    endcase
  endfunction

  function automatic biu_pkg::hburst_t type2hburst(input biu_pkg::btype_t btype);
    case (btype)
      biu_pkg::SINGLE: return biu_pkg::HBURST_SINGLE;
      biu_pkg::INCR:   return biu_pkg::HBURST_INCR;
      biu_pkg::WRAP4:  return biu_pkg::HBURST_WRAP4;
      biu_pkg::INCR4:  return biu_pkg::HBURST_INCR4;
      biu_pkg::WRAP8:  return biu_pkg::HBURST_WRAP8;
      biu_pkg::INCR8:  return biu_pkg::HBURST_INCR8;
      biu_pkg::WRAP16: return biu_pkg::HBURST_WRAP16;
      default:         return biu_pkg::HBURST_INCR16;
    endcase
  endfunction

  function automatic biu_pkg::hprot_t prot2hprot(input biu_pkg::prot_t prot);
    biu_pkg::hprot_t hp;
    hp = '0;  // opcode, user, non-cacheable
    if ((prot & biu_pkg::PROT_DATA) != '0)
      hp = hp | biu_pkg::HPROT_DATA;
    if ((prot & biu_pkg::PROT_PRIVILEGED) != '0)
      hp = hp | biu_pkg::HPROT_PRIVILEGED;
    if ((prot & biu_pkg::PROT_CACHEABLE) != '0)
      hp = hp | biu_pkg::HPROT_CACHEABLE;
    return hp;
  endfunction

  // word step, low bits kept inside the wrap window
  function automatic biu_pkg::addr_t nxt_addr(input biu_pkg::addr_t  addr,
                                               input biu_pkg::hburst_t hburst);
    biu_pkg::addr_t lin;
    lin = (addr + 32'd4) & ~32'd3;
    case (hburst)
      biu_pkg::HBURST_WRAP4:  return {addr[biu_pkg::PLEN-1:4], lin[3:0]};  // 16 bytes
      biu_pkg::HBURST_WRAP8:  return {addr[biu_pkg::PLEN-1:5], lin[4:0]};  // 32 bytes
      biu_pkg::HBURST_WRAP16: return {addr[biu_pkg::PLEN-1:6], lin[5:0]};  // 64 bytes
      default:                return lin;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // address phase
  //////////////////////////////////////////////////////////////////////

  state_t           state;
  logic [4:0]       burst_cnt;   // beats left, incl. the one on the bus
  logic             burst_done;  // nothing more to issue
  logic             dphase;      // a beat sits in its data phase
  logic             hsel;
  logic             hwrite;
  logic             hmastlock;
  biu_pkg::addr_t   haddr;
  biu_pkg::data_t   hwdata;
  biu_pkg::hsize_t  hsize;
  biu_pkg::hburst_t hburst;
  biu_pkg::hprot_t  hprot;
  biu_pkg::htrans_t htrans;

  assign burst_done = (burst_cnt <= 5'd1);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= ST_IDLE;
      burst_cnt <= '0;
      hsel      <= 1'b0;
      haddr     <= '0;
      hwrite    <= 1'b0;
      hsize     <= biu_pkg::HSIZE_WORD;
      hburst    <= biu_pkg::HBURST_SINGLE;
      hprot     <= biu_pkg::HPROT_DATA | biu_pkg::HPROT_PRIVILEGED;
      htrans    <= biu_pkg::IDLE;
      hmastlock <= 1'b0;
    end else if (ahb_i.hready) begin
      if (!burst_done) begin  // next beat of running burst
        state     <= ST_BURST;
        burst_cnt <= burst_cnt - 5'd1;
        htrans    <= biu_pkg::SEQ;
        haddr     <= nxt_addr(haddr, hburst);
      end else if (stb_ack_o) begin  // new request
        state     <= ST_BURST;
        burst_cnt <= type2len(req_i.btype);
        hsel      <= 1'b1;
        htrans    <= biu_pkg::NONSEQ;
        haddr     <= req_i.adr;
        hwrite    <= req_i.we;
        hsize     <= size2hsize(req_i.size);
        hburst    <= type2hburst(req_i.btype);
        hprot     <= prot2hprot(req_i.prot);
        hmastlock <= req_i.lock;
      end else begin
        state     <= ST_IDLE;
        burst_cnt <= '0;
        hsel      <= 1'b0;
        htrans    <= biu_pkg::IDLE;
        hmastlock <= 1'b0;
      end
    end else if (ahb_i.hresp == biu_pkg::HRESP_ERROR) begin
      // first error cycle, cancel whatever follows
      state     <= ST_ABORT;
      burst_cnt <= '0;
      hsel      <= 1'b0;
      htrans    <= biu_pkg::IDLE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn)
      dphase <= 1'b0;
    else if (ahb_i.hready)
      dphase <= (state == ST_BURST);  // address phase moves on
  end

  // write data and beat address follow the address phase by one stage
  always_ff @(posedge HCLK) begin
    if (ahb_i.hready) begin
      hwdata <= wdata_i;
      adr_o  <= haddr;
    end
  end

  assign stb_ack_o = stb_i & ahb_i.hready & burst_done & (state != ST_ABORT);
  assign d_ack_o   = ahb_i.hready & (state == ST_BURST);
  assign ack_o     = ahb_i.hready & dphase & (ahb_i.hresp == biu_pkg::HRESP_OKAY);
  assign err_o     = (state == ST_ABORT);  // one cycle, with the 2nd error cycle
  assign rdata_o   = ahb_i.hrdata;

  assign ahb_o = '{hsel:      hsel,
                   haddr:     haddr,
                   hwdata:    hwdata,
                   hwrite:    hwrite,
                   hsize:     hsize,
                   hburst:    hburst,
                   hprot:     hprot,
                   htrans:    htrans,
                   hmastlock: hmastlock};

  // a SEQ beat only ever continues a burst with beats left
  a_seq_in_burst: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (ahb_o.htrans == biu_pkg::SEQ) |-> (burst_cnt != '0));

  // failed beat is never acknowledged
  a_err_no_ack: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(err_o && ack_o));

endmodule

`default_nettype wire

/* src/biu_pkg.sv */
`default_nettype none

package biu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and core side types
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN = 32;  // data bus
  localparam int PLEN = 32;  // physical address

  typedef logic [PLEN-1:0] addr_t;  // byte address
  typedef logic [XLEN-1:0] data_t;
  typedef logic [2:0]      size_t;  // 0 byte, 1 halfword, 2 word
  typedef logic [2:0]      prot_t;

  // core burst request, same numbering as HBURST
  typedef enum logic [2:0] {
    SINGLE = 3'd0,
    INCR   = 3'd1,
    WRAP4  = 3'd2,
    INCR4  = 3'd3,
    WRAP8  = 3'd4,
    INCR8  = 3'd5,
    WRAP16 = 3'd6,
    INCR16 = 3'd7
  } btype_t;

  localparam prot_t PROT_DATA       = 3'b001;  // data, else opcode fetch
  localparam prot_t PROT_PRIVILEGED = 3'b010;
  localparam prot_t PROT_CACHEABLE  = 3'b100;

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  //////////////////////////////////////////////////////////////////////

  typedef logic [2:0] hsize_t;
  typedef logic [2:0] hburst_t;
  typedef logic [3:0] hprot_t;

  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  localparam hburst_t HBURST_SINGLE = 3'b000;
  localparam hburst_t HBURST_INCR   = 3'b001;
  localparam hburst_t HBURST_WRAP4  = 3'b010;
  localparam hburst_t HBURST_INCR4  = 3'b011;
  localparam hburst_t HBURST_WRAP8  = 3'b100;
  localparam hburst_t HBURST_INCR8  = 3'b101;
  localparam hburst_t HBURST_WRAP16 = 3'b110;
  localparam hburst_t HBURST_INCR16 = 3'b111;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,  // never issued by this master
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  localparam hprot_t HPROT_DATA       = 4'b0001;
  localparam hprot_t HPROT_PRIVILEGED = 4'b0010;
  localparam hprot_t HPROT_CACHEABLE  = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    addr_t  adr;
    size_t  size;
    btype_t btype;
    prot_t  prot;
    logic   lock;
    logic   we;
  } biu_req_t;

  typedef struct packed {
    logic    hsel;
    addr_t   haddr;
    data_t   hwdata;
    logic    hwrite;
    hsize_t  hsize;
    hburst_t hburst;
    hprot_t  hprot;
    htrans_t htrans;
    logic    hmastlock;
  } ahb_m2s_t;

  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_s2m_t;

  // sram geometry, 1 KiB of words aliased below the error region
  localparam int    MEM_WORDS = 256;
  localparam int    MEM_AW    = $clog2(MEM_WORDS);
  localparam addr_t ERR_BASE  = 32'h0000_0800;

endpackage

`default_nettype wire

/* src/biu_subsys.sv */
`default_nettype none

module biu_subsys (
  input  logic              HCLK,
  input  logic              HRESETn,
  // core port
  input  logic              stb_i,
  input  biu_pkg::biu_req_t req_i,
  input  biu_pkg::data_t    wdata_i,
  output logic              stb_ack_o,
  output logic              d_ack_o,
  output biu_pkg::addr_t    adr_o,
  output biu_pkg::data_t    rdata_o,
  output logic              ack_o,
  output logic              err_o
);

  biu_pkg::ahb_m2s_t ahb_m2s;  // master to slave
  biu_pkg::ahb_s2m_t ahb_s2m;  // slave to master, hready fed back

  biu_ahb_master biu_ahb_master_inst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .stb_i     (stb_i),
    .req_i     (req_i),
    .wdata_i   (wdata_i),
    .stb_ack_o (stb_ack_o),
    .d_ack_o   (d_ack_o),
    .adr_o     (adr_o),
    .rdata_o   (rdata_o),
    .ack_o     (ack_o),
    .err_o     (err_o),
    .ahb_o     (ahb_m2s),
    .ahb_i     (ahb_s2m)
  );

  // single slave, no decoder, hsel straight from master
  ahb_sram_slave ahb_sram_slave_inst (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ahb_i   (ahb_m2s),
    .ahb_o   (ahb_s2m)
  );

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
src/biu_pkg.sv
src/biu_ahb_master.sv
src/ahb_sram_slave.sv
src/biu_subsys.sv
bench/biu_tb.sv
